// ==== compile.f ====
uart_pkg.sv
axis_if.sv
axis_uart_rx.sv
axis_uart_tx.sv
axis_fifo.sv
uart_top.sv
uart_top_chk.sv
tb_uart_top.sv

// ==== Bender.yml ====
package:
  name: uart_top

sources:
  # design, in compile order
  - files:
      - uart_pkg.sv
      - axis_if.sv
      - axis_uart_rx.sv
      - axis_uart_tx.sv
      - axis_fifo.sv
      - uart_top.sv

  # testbench and bound checker
  - target: test
    files:
      - uart_top_chk.sv
      - tb_uart_top.sv

// ==== tb_uart_top.sv ====
/*
 * uart subsystem testbench
 * Drives serial frames into the receiver and host bytes into the
 * transmitter, with random data from an LCG, and checks the FIFO
 * output, the overflow flag and the serial output against a model.
 */
`timescale 1ns/1ns

module tb_uart_top;

    localparam int unsigned CLK_FREQ    = 8_000_000;
    localparam int unsigned BAUD_RATE   = 1_000_000;
    localparam int unsigned FIFO_DEPTH  = 4;
    localparam int unsigned BIT_CLKS    = CLK_FREQ / BAUD_RATE;
    localparam int unsigned FRAME_CLKS  = 10 * BIT_CLKS;
    localparam int unsigned RESET_CLKS  = 10;
    localparam int unsigned CYCLE_LIMIT = 2 * 25 * FRAME_CLKS; // twice about 25 frames

    logic            clk_i = 1'b0;
    logic            arstn_i;
    logic            uart_rx_i;
    uart_pkg::data_t m_tdata_o;
    logic            m_tvalid_o;
    logic            m_tready_i;
    uart_pkg::data_t s_tdata_i;
    logic            s_tvalid_i;
    logic            s_tready_o;
    logic            uart_tx_o;
    logic            overflow_o;

    uart_pkg::data_t exp_q[$];    // bytes expected from the rx FIFO
    uart_pkg::data_t tx_exp_q[$]; // bytes accepted by the transmitter
    logic            exp_overflow;
    int unsigned     rx_count;
    int unsigned     cycle_cnt = 0;
    logic [31:0]     lcg_state = 32'hc0af559b;

    uart_top #(
        .CLK_FREQ   (CLK_FREQ),
        .BAUD_RATE  (BAUD_RATE),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) uart_top_i (
        .clk_i      (clk_i),
        .arstn_i    (arstn_i),
        .uart_rx_i  (uart_rx_i),
        .m_tdata_o  (m_tdata_o),
        .m_tvalid_o (m_tvalid_o),
        .m_tready_i (m_tready_i),
        .s_tdata_i  (s_tdata_i),
        .s_tvalid_i (s_tvalid_i),
        .s_tready_o (s_tready_o),
        .uart_tx_o  (uart_tx_o),
        .overflow_o (overflow_o)
    );

    always #20 clk_i = ~clk_i;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            fail_run($sformatf("[ERROR] %s expected %0h actual %0h", name, expected, actual));
        end
    endtask

    task automatic apply_reset();
        arstn_i = 1'b0;
        exp_q.delete();
        exp_overflow = 1'b0;
        rx_count = 0;
        repeat (RESET_CLKS) @(posedge clk_i);
        #2;
        arstn_i = 1'b1;
    endtask

    task automatic drive_rx_bit(input logic b);
        uart_rx_i = b;
        repeat (BIT_CLKS) @(posedge clk_i);
        #2;
    endtask

    // model update before the 8N1 frame goes out
    task automatic send_rx_byte(input uart_pkg::data_t b);
        int i;
        if (exp_q.size() < FIFO_DEPTH) begin
            exp_q.push_back(b);
        end else begin
            exp_overflow = 1'b1; // byte lost on a full fifo
        end
        drive_rx_bit(1'b0);
        for (i = 0; i < uart_pkg::DATA_W; i++) begin
            drive_rx_bit(b[i]);
        end
        drive_rx_bit(1'b1);
    endtask

    task automatic drain_rx_fifo();
        @(negedge clk_i);
        while (m_tvalid_o) @(negedge clk_i);
        repeat (4) @(posedge clk_i); // room for any stray byte
        #2;
    endtask

    task automatic offer_tx_byte(input uart_pkg::data_t b);
        s_tdata_i  = b;
        s_tvalid_i = 1'b1;
        @(negedge clk_i);
        while (!s_tready_o) @(negedge clk_i);
        tx_exp_q.push_back(b); // transfer on the coming edge
        @(posedge clk_i);
        #2;
        s_tvalid_i = 1'b0;
    endtask

    task automatic capture_tx_frame();
        uart_pkg::data_t got;
        uart_pkg::data_t exp;
        int i;
        @(negedge uart_tx_o);
        repeat (BIT_CLKS / 2) @(negedge clk_i); // middle of start bit
        check_value("tx_start_bit", 0, uart_tx_o);
        for (i = 0; i < uart_pkg::DATA_W; i++) begin
            repeat (BIT_CLKS) @(negedge clk_i);
            got[i] = uart_tx_o;
        end
        repeat (BIT_CLKS) @(negedge clk_i);
        check_value("tx_stop_bit", 1, uart_tx_o);
        if (tx_exp_q.size() == 0) begin
            fail_run("frame seen on uart_tx_o without a byte handed to the transmitter");
        end
        exp = tx_exp_q.pop_front();
        check_value("tx_data", exp, got);
    endtask

    // handshake seen here completes on the next rising edge
    always @(negedge clk_i) begin
        if (arstn_i && m_tvalid_o && m_tready_i) begin
            if (exp_q.size() == 0) begin
                fail_run($sformatf("unexpected byte %0h read from the rx FIFO", m_tdata_o));
            end
            check_value("rx_data", exp_q.pop_front(), m_tdata_o);
            rx_count++;
        end
    end

    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            fail_run($sformatf("timeout, tests did not finish within %0d cycles", CYCLE_LIMIT));
        end
    end

    initial begin
        logic [31:0] r;
        int i;
        int k;
        uart_rx_i  = 1'b1;
        m_tready_i = 1'b0;
        s_tdata_i  = '0;
        s_tvalid_i = 1'b0;
        apply_reset();
        check_value("reset_tx_line", 1, uart_tx_o);
        check_value("reset_m_tvalid", 0, m_tvalid_o);
        check_value("reset_overflow", 0, overflow_o);
        repeat (2) @(posedge clk_i);
        #2;
        check_value("reset_s_tready", 1, s_tready_o);

        m_tready_i = 1'b1; // back to back receive
        for (i = 0; i < 8; i++) begin
            r = lcg_next();
            send_rx_byte(r[23:16]);
        end
        drain_rx_fifo();
        check_value("rx_count", 8, rx_count);
        check_value("rx_overflow", 0, overflow_o);

        m_tready_i = 1'b0; // host stalls so the fifo fills up
        rx_count = 0;
        for (i = 0; i < 6; i++) begin
            r = lcg_next();
            send_rx_byte(r[23:16]);
        end
        repeat (4) @(posedge clk_i);
        #2;
        check_value("bp_overflow", exp_overflow, overflow_o);
        m_tready_i = 1'b1;
        drain_rx_fifo();
        check_value("bp_rx_count", FIFO_DEPTH, rx_count);

        apply_reset(); // glitch shorter than half a bit
        check_value("glitch_overflow", 0, overflow_o);
        uart_rx_i = 1'b0;
        repeat (2) @(posedge clk_i);
        #2;
        uart_rx_i = 1'b1;
        repeat (2 * FRAME_CLKS) begin
            @(negedge clk_i);
            check_value("glitch_m_tvalid", 0, m_tvalid_o);
        end
        @(posedge clk_i);
        #2;

        fork
            begin
                for (k = 0; k < 6; k++) begin
                    r = lcg_next();
                    repeat (r[3:0]) begin // random gap
                        @(posedge clk_i);
                        #2;
                    end
                    offer_tx_byte(r[31:24]);
                end
            end
            begin
                repeat (6) capture_tx_frame();
            end
        join
        repeat (FRAME_CLKS) begin // no frame beyond the six offered
            @(negedge clk_i);
            check_value("tx_idle_line", 1, uart_tx_o);
        end

        if (uart_top_i.chk_i.fail_cnt == 0) begin
            $display("test passed");
            $finish;
        end else begin
            fail_run("concurrent assertions failed in the bound checker");
        end
    end

endmodule

// ==== uart_top_chk.sv ====
/*
 * uart subsystem checker
 * Concurrent assertions on the top-level ports, bound into uart_top.
 */
`timescale 1ns/1ns

module uart_top_chk (
    input logic            clk_i,
    input logic            arstn_i,
    input uart_pkg::data_t m_tdata_o,
    input logic            m_tvalid_o,
    input logic            m_tready_i,
    input logic            s_tready_o,
    input logic            uart_tx_o,
    input logic            overflow_o
);

    int unsigned fail_cnt = 0;

    tx_idle_high: assert property (@(posedge clk_i) disable iff (!arstn_i)
        s_tready_o |-> uart_tx_o)
        else begin
            fail_cnt++;
            $error("uart_tx_o low while the transmitter is ready");
        end

    rx_data_held: assert property (@(posedge clk_i) disable iff (!arstn_i)
        (m_tvalid_o && !m_tready_i) |=> $stable(m_tdata_o))
        else begin
            fail_cnt++;
            $error("m_tdata_o changed while stalled");
        end

    overflow_sticky: assert property (@(posedge clk_i) disable iff (!arstn_i)
        !$fell(overflow_o))
        else begin
            fail_cnt++;
            $error("overflow_o cleared without reset");
        end

endmodule

bind uart_top uart_top_chk chk_i (.*);

// ==== uart_top.sv ====
/*
 * uart subsystem
 * Serial receiver into a FIFO read by the host over AXI-stream, and
 * a serial transmitter fed by the host over AXI-stream. A sticky
 * overflow flag records any byte dropped while the FIFO was full.
 */
`timescale 1ns/1ns

module uart_top #(
    parameter int unsigned CLK_FREQ   = 27_000_000,
    parameter int unsigned BAUD_RATE  = 115_200,
    parameter int unsigned FIFO_DEPTH = 8
) (
    input  logic            clk_i,
    input  logic            arstn_i,
    input  logic            uart_rx_i,
    output uart_pkg::data_t m_tdata_o,
    output logic            m_tvalid_o,
    input  logic            m_tready_i,
    input  uart_pkg::data_t s_tdata_i,
    input  logic            s_tvalid_i,
    output logic            s_tready_o,
    output logic            uart_tx_o,
    output logic            overflow_o
);

    axis_if rx_axis ();
    axis_if fifo_out_axis ();
    axis_if tx_axis ();

    logic overflow_q;

    axis_uart_rx #(
        .CLK_FREQ  (CLK_FREQ),
        .BAUD_RATE (BAUD_RATE)
    ) u_uart_rx (
        .clk_i     (clk_i),
        .arstn_i   (arstn_i),
        .uart_rx_i (uart_rx_i),
        .m_axis    (rx_axis.master)
    );

    axis_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_rx_fifo (
        .clk_i   (clk_i),
        .arstn_i (arstn_i),
        .s_axis  (rx_axis.slave),
        .m_axis  (fifo_out_axis.master)
    );

    axis_uart_tx #(
        .CLK_FREQ  (CLK_FREQ),
        .BAUD_RATE (BAUD_RATE)
    ) u_uart_tx (
        .clk_i     (clk_i),
        .arstn_i   (arstn_i),
        .s_axis    (tx_axis.slave),
        .uart_tx_o (uart_tx_o)
    );

    assign m_tdata_o            = fifo_out_axis.tdata;
    assign m_tvalid_o           = fifo_out_axis.tvalid;
    assign fifo_out_axis.tready = m_tready_i;

    assign tx_axis.tdata  = s_tdata_i;
    assign tx_axis.tvalid = s_tvalid_i;
    assign s_tready_o     = tx_axis.tready;

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            overflow_q <= 1'b0;
        end else if (rx_axis.tvalid && !rx_axis.tready) begin
            overflow_q <= 1'b1; // byte lost, fifo full
        end
    end

    assign overflow_o = overflow_q;

endmodule

// ==== axis_fifo.sv ====
/*
 * AXI-stream FIFO
 * Synchronous circular buffer with first-word fall-through output.
 * A read and a write may happen in the same cycle. Pointers carry
 * one wrap bit to tell full from empty.
 */
`timescale 1ns/1ns

module axis_fifo #(
    parameter int unsigned FIFO_DEPTH = 8
) (
    input  logic   clk_i,
    input  logic   arstn_i,
    axis_if.slave  s_axis,
    axis_if.master m_axis
);

    localparam int unsigned ADDR_W = $clog2(FIFO_DEPTH);
    localparam int unsigned PTR_W  = ADDR_W + 1;

    uart_pkg::data_t  mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             full;
    logic             empty;
    logic             wr_en;
    logic             rd_en;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[PTR_W-1] != rd_ptr[PTR_W-1]) &&
                   (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]); // same slot, other lap

    assign wr_en = s_axis.tvalid && !full;
    assign rd_en = m_axis.tready && !empty;

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            wr_ptr <= '0;
        end else if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            rd_ptr <= '0;
        end else if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            mem[wr_ptr[ADDR_W-1:0]] <= s_axis.tdata;
        end
    end

    assign s_axis.tready = !full;
    assign m_axis.tvalid = !empty;
    assign m_axis.tdata  = mem[rd_ptr[ADDR_W-1:0]]; // head word, no read latency

endmodule

// ==== axis_uart_tx.sv ====
/*
 * uart transmitter
 * Takes one data word per AXI-stream transfer and sends it as an
 * 8N1 frame on the serial line, LSB first. Ready only while idle.
 */
`timescale 1ns/1ns

module axis_uart_tx #(
    parameter int unsigned CLK_FREQ  = 27_000_000,
    parameter int unsigned BAUD_RATE = 115_200
) (
    input  logic  clk_i,
    input  logic  arstn_i,
    axis_if.slave s_axis,
    output logic  uart_tx_o
);

    localparam int unsigned RATIO = CLK_FREQ / BAUD_RATE;
    localparam int unsigned CNT_W = $clog2(RATIO);
    localparam int unsigned BIT_W = $clog2(uart_pkg::DATA_W);

    uart_pkg::tx_state_t state;
    logic [CNT_W-1:0]    baud_cnt;
    logic [BIT_W-1:0]    bit_cnt;
    uart_pkg::data_t     tx_shift;
    logic                ready_q;
    logic                tx_q;
    logic                take;
    logic                baud_done;
    logic                last_bit;

    assign take      = s_axis.tvalid && ready_q;
    assign baud_done = (baud_cnt == CNT_W'(RATIO - 1));
    assign last_bit  = (bit_cnt == BIT_W'(uart_pkg::DATA_W - 1));

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            state   <= uart_pkg::TX_IDLE;
            ready_q <= 1'b0;
            tx_q    <= 1'b1; // line idles high
        end else begin
            case (state)
                uart_pkg::TX_IDLE: begin
                    ready_q <= 1'b1;
                    if (take) begin
                        ready_q <= 1'b0;
                        tx_q    <= 1'b0; // start bit
                        state   <= uart_pkg::TX_START;
                    end
                end
                uart_pkg::TX_START: begin
                    if (baud_done) begin
                        tx_q  <= tx_shift[0];
                        state <= uart_pkg::TX_DATA;
                    end
                end
                uart_pkg::TX_DATA: begin
                    if (baud_done) begin
                        tx_q <= last_bit ? 1'b1 : tx_shift[0];
                        if (last_bit) begin
                            state <= uart_pkg::TX_STOP;
                        end
                    end
                end
                uart_pkg::TX_STOP: begin
                    if (baud_done) begin
                        state <= uart_pkg::TX_IDLE;
                    end
                end
                default: begin
                    state <= uart_pkg::TX_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            baud_cnt <= '0;
        end else if ((state == uart_pkg::TX_IDLE) || baud_done) begin
            baud_cnt <= '0;
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            bit_cnt <= '0;
        end else if (state != uart_pkg::TX_DATA) begin
            bit_cnt <= '0;
        end else if (baud_done) begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (take) begin
            tx_shift <= s_axis.tdata;
        end else if (baud_done && (state != uart_pkg::TX_IDLE)) begin
            tx_shift <= tx_shift >> 1; // next bit to position 0
        end
    end

    assign s_axis.tready = ready_q;
    assign uart_tx_o     = tx_q;

endmodule

// ==== axis_uart_rx.sv ====
/*
 * uart receiver
 * Turns 8N1 frames on the serial line into data words on an
 * AXI-stream master. Short low pulses are rejected at the middle of
 * the start bit, data bits are sampled mid-bit, LSB first. tvalid is
 * a one-cycle pulse and does not wait for tready.
 */
`timescale 1ns/1ns

module axis_uart_rx #(
    parameter int unsigned CLK_FREQ  = 27_000_000,
    parameter int unsigned BAUD_RATE = 115_200
) (
    input  logic   clk_i,
    input  logic   arstn_i,
    input  logic   uart_rx_i,
    axis_if.master m_axis
);

    localparam int unsigned RATIO = CLK_FREQ / BAUD_RATE;
    localparam int unsigned CNT_W = $clog2(RATIO);
    localparam int unsigned BIT_W = $clog2(uart_pkg::DATA_W);

    uart_pkg::rx_state_t state;
    logic [CNT_W-1:0]    baud_cnt;
    logic [BIT_W-1:0]    bit_cnt;
    uart_pkg::data_t     rx_shift;
    logic                half_done;
    logic                baud_done;
    logic                last_bit;
    logic                counting;

    assign counting  = (state == uart_pkg::RX_START) || (state == uart_pkg::RX_DATA) ||
                       (state == uart_pkg::RX_STOP);
    assign half_done = (state == uart_pkg::RX_START) && (baud_cnt == CNT_W'(RATIO / 2 - 1));
    assign baud_done = (baud_cnt == CNT_W'(RATIO - 1));
    assign last_bit  = (bit_cnt == BIT_W'(uart_pkg::DATA_W - 1));

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            state <= uart_pkg::RX_IDLE;
        end else begin
            case (state)
                uart_pkg::RX_IDLE: begin
                    if (!uart_rx_i) begin // falling edge of start bit
                        state <= uart_pkg::RX_START;
                    end
                end
                uart_pkg::RX_START: begin
                    if (half_done) begin
                        state <= uart_rx_i ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA; // glitch check
                    end
                end
                uart_pkg::RX_DATA: begin
                    if (baud_done && last_bit) begin
                        state <= uart_pkg::RX_STOP;
                    end
                end
                uart_pkg::RX_STOP: begin
                    if (baud_done) begin // stop bit not checked
                        state <= uart_pkg::RX_WAIT;
                    end
                end
                uart_pkg::RX_WAIT: begin
                    state <= uart_pkg::RX_IDLE;
                end
                default: begin
                    state <= uart_pkg::RX_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            baud_cnt <= '0;
        end else if (!counting || half_done || baud_done) begin
            baud_cnt <= '0; // restart at mid start bit so samples land mid-bit
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            bit_cnt <= '0;
        end else if (state != uart_pkg::RX_DATA) begin
            bit_cnt <= '0;
        end else if (baud_done) begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if ((state == uart_pkg::RX_DATA) && baud_done) begin
            rx_shift <= {uart_rx_i, rx_shift[uart_pkg::DATA_W-1:1]}; // lsb first
        end
    end

    assign m_axis.tdata  = rx_shift;
    assign m_axis.tvalid = (state == uart_pkg::RX_WAIT);

endmodule

// ==== axis_if.sv ====
/*
 * AXI-stream link
 * Carries one data word per transfer. A transfer happens in a cycle
 * where tvalid and tready are both high.
 */
`timescale 1ns/1ns

interface axis_if;

    uart_pkg::data_t tdata;
    logic            tvalid;
    logic            tready;

    modport master (
        output tdata,
        output tvalid,
        input  tready
    );

    modport slave (
        input  tdata,
        input  tvalid,
        output tready
    );

endinterface

// ==== uart_pkg.sv ====
/*
 * uart package
 * Shared data word type and the FSM state encodings of the
 * serial receiver and transmitter.
 */
package uart_pkg;

    localparam int unsigned DATA_W = 8;

    typedef logic [DATA_W-1:0] data_t; // one uart data word

    typedef enum logic [2:0] {
        RX_IDLE  = 3'd0,
        RX_START = 3'd1,
        RX_DATA  = 3'd2,
        RX_STOP  = 3'd3,
        RX_WAIT  = 3'd4
    } rx_state_t;

    typedef enum logic [1:0] {
        TX_IDLE  = 2'd0,
        TX_START = 2'd1,
        TX_DATA  = 2'd2,
        TX_STOP  = 2'd3
    } tx_state_t;

endpackage
